// File: sim.f
+incdir+src
src/scope_pkg.sv
src/stream_skid.sv
src/eq_fir.sv
src/eq_pole_a.sv
src/eq_pole_p.sv
src/eq_scale_sat.sv
src/scope_filter.sv
sim/scope_filter_asserts.sv
sim/scope_filter_tb.sv

// File: run.sh
#!/bin/sh
# build and run the scope equalizer testbench with verilator
# the result is taken from the testbench output text

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module scope_filter_tb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vscope_filter_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
  exit 0
fi
exit 1

// File: sim/scope_filter_tb.sv
// testbench for the scope equalizer
// random and directed streams against a bit-true model of the four
// stages, with output stalls, input gaps, mid-run reset and latency
`timescale 1ns/1ps
`include "scope_macros.svh"

module scope_filter_tb import scope_pkg::*; ();

  localparam logic [31:0] SEED = 32'hded7;

  logic        clk;
  logic        rstn;
  adc_sample_t sti_dat;
  logic        sti_vld;
  logic        sti_rdy;
  adc_sample_t sto_dat;
  logic        sto_sat;
  logic        sto_vld;
  logic        sto_rdy = 1'b1;
  coef_aa_t    cfg_aa;
  coef_t       cfg_bb, cfg_kk, cfg_pp;

  logic [31:0] rng;                                   // stimulus stream
  logic [31:0] rdy_rng = {SEED[15:0], SEED[31:16]};   // stall stream
  int unsigned stall_pct = 0;  // chance of sto_rdy low
  string       test_name = "reset";
  int          errors = 0;
  int          n_checks = 0;
  int          n_sent = 0;     // sets the timeout
  int          cyc = 0;
  int          t_in = -1;      // cycle of first accept after reset
  bit          out_seen = 1'b0;
  int          n_sat_pos = 0;
  int          n_sat_neg = 0;
  int          sat_pos_base, sat_neg_base;
  scope_out_t  exp_q[$];       // expected, oldest first
  scope_out_t  exp_s;
  longint      m_xprev, m_y, m_z;  // model state

  scope_filter u_dut (
    .clk(clk), .rstn(rstn),
    .sti_dat(sti_dat), .sti_vld(sti_vld), .sti_rdy(sti_rdy),
    .sto_dat(sto_dat), .sto_sat(sto_sat), .sto_vld(sto_vld), .sto_rdy(sto_rdy),
    .cfg_aa(cfg_aa), .cfg_bb(cfg_bb), .cfg_kk(cfg_kk), .cfg_pp(cfg_pp)
  );

  bind scope_filter scope_filter_asserts u_asserts (
    .clk(clk), .rstn(rstn),
    .sti_dat(sti_dat), .sti_vld(sti_vld), .sti_rdy(sti_rdy),
    .sto_dat(sto_dat), .sto_sat(sto_sat), .sto_vld(sto_vld), .sto_rdy(sto_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  // keep low w bits, sign extended
  function automatic longint wrap(input longint v, input int w);
    return (v <<< (64 - w)) >>> (64 - w);
  endfunction

  // bit-true model of one sample through all four stages
  function automatic scope_out_t model_step(input adc_sample_t x);
    longint     acc;
    longint     w;    // fir result
    longint     nar;  // pole a result, narrowed
    longint     m;    // after gain
    scope_out_t r;
    acc = (longint'(x) <<< 18) + (longint'(cfg_bb) - (64'sd1 <<< 18)) * m_xprev;
    w = wrap(acc >>> `SCOPE_SHR_FIR, `SCOPE_DW_FIR);
    m_xprev = longint'(x);
    acc = ((w + m_y) <<< `SCOPE_SHR_AA) - longint'(cfg_aa) * m_y;  // leak aa*y
    m_y = wrap(acc >>> `SCOPE_SHR_AA, `SCOPE_DW_FIR);
    nar = wrap(m_y >>> `SCOPE_SHR_NARROW, `SCOPE_DW_POLE_P);
    m_z = wrap(nar + ((longint'(cfg_pp) * m_z) >>> `SCOPE_SHR_PP), `SCOPE_DW_POLE_P);
    m = (longint'(cfg_kk) * m_z) >>> `SCOPE_SHR_KK;
    r.sat = (m > 64'sd8191) || (m < -64'sd8192);
    if (m > 64'sd8191) begin
      m = 64'sd8191;
    end else if (m < -64'sd8192) begin
      m = -64'sd8192;
    end
    r.dat = m[13:0];
    return r;
  endfunction

  task automatic check(input string name, input int expected, input int actual);
    n_checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic apply_reset();
    rstn <= 1'b0;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
  endtask

  // one sample, after a random number of idle cycles
  task automatic send(input adc_sample_t d, input int unsigned gap_pct);
    logic [31:0] r;
    r = rand32();
    while (r % 100 < gap_pct) begin
      @(posedge clk);
      r = rand32();
    end
    sti_dat <= d;
    sti_vld <= 1'b1;
    n_sent++;
    @(posedge clk);
    while (!sti_rdy) begin
      @(posedge clk);  // held until taken
    end
    sti_vld <= 1'b0;
  endtask

  task automatic run_random(input int n, input int unsigned gap_pct);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = rand32();
      send(r[13:0], gap_pct);
    end
  endtask

  task automatic random_coefs();
    logic [31:0] r;
    r = rand32();
    cfg_aa <= r[17:0];
    r = rand32();
    cfg_bb <= r[24:0];
    r = rand32();
    cfg_pp <= r[24:0];
    r = rand32();
    cfg_kk <= r[24:0];
  endtask

  // all expected samples out within a bounded wait
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 200) begin
      @(posedge clk);
      waited++;
    end
    check({test_name, " queue empty"}, 0, exp_q.size());
    repeat (8) @(posedge clk);  // room for stray extra outputs
  endtask

  always @(posedge clk) begin
    rdy_rng = xorshift(rdy_rng);
    sto_rdy <= (rdy_rng % 100) >= stall_pct;
  end

  ////////////////////
  // compare
  ////////////////////

  always @(posedge clk) begin
    if (!rstn) begin
      m_xprev = 0;  // model follows the dut reset
      m_y = 0;
      m_z = 0;
      exp_q.delete();
      t_in = -1;
      out_seen = 1'b0;
    end else begin
      if (sti_vld && sti_rdy) begin
        if (t_in < 0) begin
          t_in = cyc;
        end
        exp_q.push_back(model_step(sti_dat));
      end
      if (sto_vld && !out_seen) begin
        out_seen = 1'b1;
        check("latency", 6, cyc - t_in);  // 2 skids + 4 stages
      end
      if (sto_vld && sto_rdy) begin
        if (sto_sat) begin
          if (sto_dat[13]) begin
            n_sat_neg++;
          end else begin
            n_sat_pos++;
          end
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("output transfer of %0d with no sample left to expect", sto_dat);
        end else begin
          exp_s = exp_q.pop_front();
          check(test_name, int'(exp_s.dat), int'(sto_dat));
          check({test_name, " sat"}, int'(exp_s.sat), int'(sto_sat));
        end
      end
    end
  end

  // run limit grows with the samples issued
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > 20 * n_sent + 200) begin
      $display("timeout after %0d cycles, the stream stopped moving", cyc);
      $display("checks %0d, errors %0d", n_checks, errors);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    rng = SEED;
    rstn = 1'b0;
    sti_dat = '0;
    sti_vld = 1'b0;
    cfg_aa = '0;               // no leak, pure integrator
    cfg_bb = 25'sh004_0000;    // 1.0, no x_prev term
    cfg_pp = '0;
    cfg_kk = 25'sh0ff_ffff;    // just under unity
    apply_reset();

    test_name = "identity";    // also the latency case, sto_rdy high
    run_random(64, 0);
    drain();

    test_name = "random";
    repeat (3) begin
      random_coefs();
      apply_reset();
      run_random(150, 10);
      drain();
    end

    // dc held in pole a, pole p doubles it past full scale
    test_name = "saturation";
    cfg_aa <= '0;
    cfg_bb <= 25'sh004_0000;
    cfg_pp <= 25'sh000_8000;   // 0.5
    cfg_kk <= 25'sh0ff_ffff;
    apply_reset();
    sat_pos_base = n_sat_pos;
    sat_neg_base = n_sat_neg;
    send(14'sd8191, 0);
    repeat (20) send(14'sd0, 0);
    send(-14'sd8191, 0);
    send(-14'sd8191, 0);
    repeat (20) send(14'sd0, 0);
    send(14'sd8191, 0);        // back to zero
    repeat (20) send(14'sd0, 0);
    drain();
    check("positive clip seen", 1, int'(n_sat_pos > sat_pos_base));
    check("negative clip seen", 1, int'(n_sat_neg > sat_neg_base));

    test_name = "backpressure";
    stall_pct = 40;
    random_coefs();
    apply_reset();
    run_random(300, 30);
    drain();
    stall_pct = 0;

    // build up state, reset, then an impulse from zero state
    test_name = "impulse";
    cfg_aa <= 18'sh1_0000;
    cfg_bb <= 25'sh003_0000;
    cfg_pp <= 25'sh000_8000;
    cfg_kk <= 25'sh080_0000;
    apply_reset();
    run_random(40, 20);
    drain();
    apply_reset();
    send(14'sd8191, 0);
    repeat (15) send(14'sd0, 0);
    drain();

    $display("checks %0d, errors %0d", n_checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : scope_filter_tb

// File: sim/scope_filter_asserts.sv
// stream protocol checks for the scope equalizer
// bound into the top level, watches both stream ports
`timescale 1ns/1ps

module scope_filter_asserts import scope_pkg::*; (
  input logic        clk,
  input logic        rstn,
  input adc_sample_t sti_dat,
  input logic        sti_vld,
  input logic        sti_rdy,
  input adc_sample_t sto_dat,
  input logic        sto_sat,
  input logic        sto_vld,
  input logic        sto_rdy
);

  logic [2:0] since_in;  // cycles since first accept, stops at 7

  always_ff @(posedge clk) begin
    if (!rstn) begin
      since_in <= '0;
    end else if (since_in == 3'd0) begin
      if (sti_vld && sti_rdy) begin
        since_in <= 3'd1;
      end
    end else if (since_in != 3'd7) begin
      since_in <= since_in + 3'd1;
    end
  end

  ////////////////////
  // properties
  ////////////////////

  a_sto_hold: assert property (@(posedge clk) disable iff (!rstn)
    sto_vld && !sto_rdy |=> sto_vld && $stable(sto_dat) && $stable(sto_sat))
    else $error("output stream changed while stalled");

  a_sti_hold: assert property (@(posedge clk) disable iff (!rstn)
    sti_vld && !sti_rdy |=> sti_vld && $stable(sti_dat))
    else $error("input stream changed while stalled");

  a_rst_idle: assert property (@(posedge clk) !rstn |=> !sto_vld)
    else $error("output valid right after reset");

  // pipeline depth is six, nothing earlier
  a_min_lat: assert property (@(posedge clk) disable iff (!rstn)
    sto_vld |-> since_in >= 3'd6)
    else $error("output valid too soon after first input");

endmodule : scope_filter_asserts

// File: src/scope_filter.sv
// oscilloscope input equalizer
// skid -> fir (bb) -> pole (aa) -> pole (pp) -> gain/sat (kk) -> skid
// six cycles input to output with no back-pressure
`timescale 1ns/1ps

module scope_filter import scope_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  // input stream
  input  adc_sample_t sti_dat,
  input  logic        sti_vld,
  output logic        sti_rdy,
  // output stream
  output adc_sample_t sto_dat,
  output logic        sto_sat,  // sample was clamped
  output logic        sto_vld,
  input  logic        sto_rdy,
  // coefficients, stable while idle
  input  coef_aa_t    cfg_aa,
  input  coef_t       cfg_bb,
  input  coef_t       cfg_kk,
  input  coef_t       cfg_pp
);

  ////////////////////
  // stage links
  ////////////////////

  adc_sample_t  sk_dat;   // skid in -> fir
  logic         sk_vld, sk_rdy;
  fir_sample_t  fir_dat;  // fir -> pole a
  logic         fir_vld, fir_rdy;
  fir_sample_t  pa_dat;   // pole a -> pole p
  logic         pa_vld, pa_rdy;
  pole_sample_t pp_dat;   // pole p -> scale
  logic         pp_vld, pp_rdy;
  scope_out_t   sc_dat;   // scale -> skid out
  logic         sc_vld, sc_rdy;
  scope_out_t   so_dat;   // skid out -> ports

  stream_skid #(.payload_t(adc_sample_t)) u_skid_in (
    .clk(clk), .rstn(rstn),
    .in_dat(sti_dat), .in_vld(sti_vld), .in_rdy(sti_rdy),
    .out_dat(sk_dat), .out_vld(sk_vld), .out_rdy(sk_rdy)
  );

  eq_fir u_fir (
    .clk(clk), .rstn(rstn),
    .in_dat(sk_dat), .in_vld(sk_vld), .in_rdy(sk_rdy),
    .out_dat(fir_dat), .out_vld(fir_vld), .out_rdy(fir_rdy),
    .cfg_bb(cfg_bb)
  );

  eq_pole_a u_pole_a (
    .clk(clk), .rstn(rstn),
    .in_dat(fir_dat), .in_vld(fir_vld), .in_rdy(fir_rdy),
    .out_dat(pa_dat), .out_vld(pa_vld), .out_rdy(pa_rdy),
    .cfg_aa(cfg_aa)
  );

  eq_pole_p u_pole_p (
    .clk(clk), .rstn(rstn),
    .in_dat(pa_dat), .in_vld(pa_vld), .in_rdy(pa_rdy),
    .out_dat(pp_dat), .out_vld(pp_vld), .out_rdy(pp_rdy),
    .cfg_pp(cfg_pp)
  );

  eq_scale_sat u_scale (
    .clk(clk), .rstn(rstn),
    .in_dat(pp_dat), .in_vld(pp_vld), .in_rdy(pp_rdy),
    .out_dat(sc_dat), .out_vld(sc_vld), .out_rdy(sc_rdy),
    .cfg_kk(cfg_kk)
  );

  stream_skid #(.payload_t(scope_out_t)) u_skid_out (
    .clk(clk), .rstn(rstn),
    .in_dat(sc_dat), .in_vld(sc_vld), .in_rdy(sc_rdy),
    .out_dat(so_dat), .out_vld(sto_vld), .out_rdy(sto_rdy)
  );

  assign sto_dat = so_dat.dat;  // split payload onto ports
  assign sto_sat = so_dat.sat;

endmodule : scope_filter

// File: src/eq_scale_sat.sv
// gain and saturation stage
// m = kk*z / 2^24 floored, clamped to the 14 bit range;
// sat flags a clamped sample
`timescale 1ns/1ps
`include "scope_macros.svh"

module eq_scale_sat import scope_pkg::*; (
  input  logic         clk,
  input  logic         rstn,
  // input stream
  input  pole_sample_t in_dat,
  input  logic         in_vld,
  output logic         in_rdy,
  // output stream
  output scope_out_t   out_dat,
  output logic         out_vld,
  input  logic         out_rdy,
  // coefficient
  input  coef_t        cfg_kk
);

  localparam int unsigned KW = `SCOPE_DW_COEF + `SCOPE_DW_POLE_P;  // product
  localparam int unsigned MW = KW - `SCOPE_SHR_KK;                 // scaled

  // output limits, +8191 / -8192
  localparam logic signed [MW-1:0] SAT_MAX = MW'(2**(`SCOPE_DW_ADC-1) - 1);
  localparam logic signed [MW-1:0] SAT_MIN = MW'(-(2**(`SCOPE_DW_ADC-1)));

  logic signed [KW-1:0] prod;
  logic signed [MW-1:0] m;      // floor(kk*z / 2^24)
  logic signed [MW-1:0] m_clp;  // clamped
  scope_out_t           res;
  logic                 in_acc;

  assign in_rdy = !out_vld || out_rdy;
  assign in_acc = in_vld && in_rdy;

  always_comb begin
    prod    = KW'(cfg_kk) * KW'(in_dat);
    m       = prod[KW-1:`SCOPE_SHR_KK];
    m_clp   = m;
    res.sat = 1'b0;
    if (m > SAT_MAX) begin
      m_clp   = SAT_MAX;  // positive clip
      res.sat = 1'b1;
    end else if (m < SAT_MIN) begin
      m_clp   = SAT_MIN;  // negative clip
      res.sat = 1'b1;
    end
    res.dat = m_clp[`SCOPE_DW_ADC-1:0];
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_vld <= 1'b0;
    end else if (in_acc) begin
      out_vld <= 1'b1;
    end else if (out_rdy) begin
      out_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_acc) begin
      out_dat <= res;
    end
  end

endmodule : eq_scale_sat

// File: src/eq_pole_p.sv
// second single-pole iir stage
// narrows the 23 bit input to 15 bits, then
// z' = narrow + pp*z / 2^16, floor, 15 bit wrap
`timescale 1ns/1ps
`include "scope_macros.svh"

module eq_pole_p import scope_pkg::*; (
  input  logic         clk,
  input  logic         rstn,
  // input stream
  input  fir_sample_t  in_dat,
  input  logic         in_vld,
  output logic         in_rdy,
  // output stream
  output pole_sample_t out_dat,
  output logic         out_vld,
  input  logic         out_rdy,
  // coefficient
  input  coef_t        cfg_pp
);

  localparam int unsigned PW = `SCOPE_DW_COEF + `SCOPE_DW_POLE_P;  // full product

  pole_sample_t         z;       // state, also output
  pole_sample_t         narrow;  // input >>> 8, wrapped
  pole_sample_t         fb;      // pp*z / 2^16
  logic signed [PW-1:0] prod;
  logic                 in_acc;

  assign in_rdy  = !out_vld || out_rdy;
  assign in_acc  = in_vld && in_rdy;
  assign out_dat = z;

  always_comb begin
    narrow = in_dat[`SCOPE_SHR_NARROW +: `SCOPE_DW_POLE_P];
    prod   = PW'(cfg_pp) * PW'(z);
    fb     = prod[`SCOPE_SHR_PP +: `SCOPE_DW_POLE_P];  // floor, low bits kept
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_vld <= 1'b0;
      z       <= '0;
    end else if (in_acc) begin
      out_vld <= 1'b1;
      z       <= narrow + fb;  // 15 bit wrap
    end else if (out_rdy) begin
      out_vld <= 1'b0;
    end
  end

endmodule : eq_pole_p

// File: src/eq_pole_a.sv
// first single-pole iir stage, high precision
// y' = (w*2^25 + y*2^25 - aa*y) / 2^25, floor, 23 bit wrap
// output is the new y
`timescale 1ns/1ps
`include "scope_macros.svh"

module eq_pole_a import scope_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  // input stream
  input  fir_sample_t in_dat,
  input  logic        in_vld,
  output logic        in_rdy,
  // output stream
  output fir_sample_t out_dat,
  output logic        out_vld,
  input  logic        out_rdy,
  // coefficient
  input  coef_aa_t    cfg_aa
);

  // (w+y) shifted up plus sign headroom
  localparam int unsigned AW = `SCOPE_DW_FIR + `SCOPE_SHR_AA + 2;

  fir_sample_t          y;      // feedback state, also output
  logic signed [AW-1:0] acc;
  fir_sample_t          y_nxt;
  logic                 in_acc;

  assign in_rdy  = !out_vld || out_rdy;
  assign in_acc  = in_vld && in_rdy;
  assign out_dat = y;

  always_comb begin
    // leak of aa*y/2^25 per sample
    acc   = ((AW'(in_dat) + AW'(y)) <<< `SCOPE_SHR_AA) - AW'(cfg_aa) * AW'(y);
    y_nxt = acc[`SCOPE_SHR_AA +: `SCOPE_DW_FIR];
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_vld <= 1'b0;
      y       <= '0;
    end else if (in_acc) begin
      out_vld <= 1'b1;
      y       <= y_nxt;  // state advances on accept only
    end else if (out_rdy) begin
      out_vld <= 1'b0;
    end
  end

endmodule : eq_pole_a

// File: src/eq_fir.sv
// first-order fir equalizer stage
// y = (x*2^18 + (bb - 2^18)*x_prev) / 2^10, floor, wrapped to 23 bits
// state moves only on an accepted sample
`timescale 1ns/1ps
`include "scope_macros.svh"

module eq_fir import scope_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  // input stream
  input  adc_sample_t in_dat,
  input  logic        in_vld,
  output logic        in_rdy,
  // output stream
  output fir_sample_t out_dat,
  output logic        out_vld,
  input  logic        out_rdy,
  // coefficient
  input  coef_t       cfg_bb
);

  localparam int unsigned ONE_SHL = 18;  // bb value of unity gain
  // bb-2^18 needs one bit more, product plus sum one more
  localparam int unsigned SW = `SCOPE_DW_COEF + `SCOPE_DW_ADC + 2;

  adc_sample_t          x_prev;  // last accepted sample
  logic signed [SW-1:0] bb_m;    // bb minus unity
  logic signed [SW-1:0] acc;     // full precision sum
  fir_sample_t          fir_res;
  logic                 in_acc;

  assign in_rdy = !out_vld || out_rdy;  // empty or being drained
  assign in_acc = in_vld && in_rdy;

  always_comb begin
    bb_m    = SW'(cfg_bb) - (SW'(1) <<< ONE_SHL);
    acc     = (SW'(in_dat) <<< ONE_SHL) + bb_m * SW'(x_prev);
    fir_res = acc[`SCOPE_SHR_FIR +: `SCOPE_DW_FIR];  // floor + wrap
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_vld <= 1'b0;
      x_prev  <= '0;
    end else if (in_acc) begin
      out_vld <= 1'b1;
      x_prev  <= in_dat;
    end else if (out_rdy) begin
      out_vld <= 1'b0;  // taken, nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (in_acc) begin
      out_dat <= fir_res;
    end
  end

endmodule : eq_fir

// File: src/stream_skid.sv
// valid/ready register slice
// main register plus one spill entry, so that in_rdy comes
// straight from a flop; one cycle latency, full rate
`timescale 1ns/1ps

module stream_skid #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rstn,
  // upstream
  input  payload_t in_dat,
  input  logic     in_vld,
  output logic     in_rdy,
  // downstream
  output payload_t out_dat,
  output logic     out_vld,
  input  logic     out_rdy
);

  payload_t main_dat;   // sample presented downstream
  payload_t spill_dat;  // caught while downstream stalls
  logic     main_vld;
  logic     spill_vld;
  logic     main_free;  // main empty or drained this cycle
  logic     in_acc;

  assign in_rdy    = !spill_vld;  // flop output, no comb path
  assign in_acc    = in_vld && in_rdy;
  assign main_free = !main_vld || out_rdy;

  assign out_dat = main_dat;
  assign out_vld = main_vld;

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      main_vld  <= 1'b0;
      spill_vld <= 1'b0;
    end else if (main_free) begin
      main_vld  <= spill_vld || in_acc;  // refill, spill first
      spill_vld <= 1'b0;
    end else if (in_acc) begin
      spill_vld <= 1'b1;  // main stuck, park the new one
    end
  end

  ////////////////////
  // data
  ////////////////////

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (spill_vld) begin
        main_dat <= spill_dat;  // oldest first, keeps order
      end else if (in_acc) begin
        main_dat <= in_dat;
      end
    end else if (in_acc) begin
      spill_dat <= in_dat;
    end
  end

endmodule : stream_skid

// File: src/scope_pkg.sv
// scope equalizer types
// sample types of each pipeline stage, coefficient
// types and the saturating output payload
`include "scope_macros.svh"

package scope_pkg;

  ////////////////////
  // samples
  ////////////////////

  // raw adc sample, two's complement
  typedef logic signed [`SCOPE_DW_ADC-1:0] adc_sample_t;

  // fir output, also first pole state
  typedef logic signed [`SCOPE_DW_FIR-1:0] fir_sample_t;

  // narrowed sample of second pole
  typedef logic signed [`SCOPE_DW_POLE_P-1:0] pole_sample_t;

  ////////////////////
  // coefficients
  ////////////////////

  typedef logic signed [`SCOPE_DW_AA-1:0] coef_aa_t;  // first pole
  typedef logic signed [`SCOPE_DW_COEF-1:0] coef_t;   // bb, pp, kk

  ////////////////////
  // output payload
  ////////////////////

  // sample after gain, with clip marker
  typedef struct packed {
    adc_sample_t dat;  // clamped sample
    logic        sat;  // 1 when clamped
  } scope_out_t;

endpackage : scope_pkg

// File: src/scope_macros.svh
// scope equalizer widths and shifts
// sample, stage and coefficient widths plus the
// fixed-point shift of every filter stage
`ifndef SCOPE_MACROS_SVH
`define SCOPE_MACROS_SVH

////////////////////
// data widths
////////////////////

`define SCOPE_DW_ADC     14  // adc sample, also output sample
`define SCOPE_DW_FIR     23  // fir output and first pole state
`define SCOPE_DW_POLE_P  15  // second pole state

// coefficient widths
`define SCOPE_DW_AA      18  // aa only
`define SCOPE_DW_COEF    25  // bb, pp, kk

////////////////////
// stage shifts
////////////////////

`define SCOPE_SHR_FIR    10  // fir sum down to 23 bits
`define SCOPE_SHR_AA     25  // first pole feedback
`define SCOPE_SHR_NARROW  8  // 23 -> 15 bits between poles
`define SCOPE_SHR_PP     16  // second pole feedback
`define SCOPE_SHR_KK     24  // gain

`endif
